//--- cv_input_pkg.sv
// Host-side input encodings: joystick word layout, keypad vector and PS/2 scan codes
package cv_input_pkg;

        // ====================================================================
        // Widths
        // ====================================================================
        localparam int JOY_W        = 32;
        localparam int PS2_KEY_W    = 11;
        localparam int KEYPAD_W     = 20;
        localparam int KBD_W        = 12;
        // Buttons that take part in the key-code priority
        localparam int KEYPAD_ENC_W = 14;

        // PS/2 event word fields
        localparam int PS2_TOGGLE_BIT  = 10;
        localparam int PS2_PRESSED_BIT = 9;
        localparam int SC_W            = 8;

        // ====================================================================
        // Button vector indices
        // ====================================================================
        localparam int KP_DIGIT0 = 0;
        localparam int KP_DIGIT3 = 3;
        localparam int KP_DIGIT8 = 8;
        localparam int KP_STAR   = 10;
        localparam int KP_NUMBER = 11;
        localparam int KP_PURPLE = 12;
        localparam int KP_BLUE   = 13;
        localparam int KP_UP     = 14;
        localparam int KP_DOWN   = 15;
        localparam int KP_LEFT   = 16;
        localparam int KP_RIGHT  = 17;
        localparam int KP_FIRE1  = 18;
        localparam int KP_FIRE2  = 19;

        // Host joystick bit positions, digits 0 to 9 are contiguous
        localparam int JOY_RIGHT  = 0;
        localparam int JOY_LEFT   = 1;
        localparam int JOY_DOWN   = 2;
        localparam int JOY_UP     = 3;
        localparam int JOY_FIRE1  = 4;
        localparam int JOY_FIRE2  = 5;
        localparam int JOY_STAR   = 6;
        localparam int JOY_NUMBER = 7;
        localparam int JOY_DIGIT0 = 8;
        localparam int JOY_PURPLE = 18;
        localparam int JOY_BLUE   = 19;

        // ====================================================================
        // PS/2 scan codes, low byte of the code field
        // ====================================================================
        // Indexed by digit value
        localparam logic [SC_W-1:0] SC_MAIN_DIGIT [10] = '{
                8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
        localparam logic [SC_W-1:0] SC_PAD_DIGIT [10] = '{
                8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D};

        localparam logic [SC_W-1:0] SC_STAR   = 8'h7C;
        localparam logic [SC_W-1:0] SC_MINUS  = 8'h7B;
        localparam logic [SC_W-1:0] SC_LSHIFT = 8'h12;
        localparam logic [SC_W-1:0] SC_RSHIFT = 8'h59;

endpackage

//--- cv_ctrl_pkg.sv
// Console controller port encodings: keypad codes, direction lines and the port nibble
package cv_ctrl_pkg;

        localparam int PORT_W = 4;

        // ====================================================================
        // Keypad codes as seen on the port lines
        // ====================================================================
        localparam logic [PORT_W-1:0] KEY_0      = 4'b0011;
        localparam logic [PORT_W-1:0] KEY_1      = 4'b1110;
        localparam logic [PORT_W-1:0] KEY_2      = 4'b1101;
        localparam logic [PORT_W-1:0] KEY_3      = 4'b0110;
        localparam logic [PORT_W-1:0] KEY_4      = 4'b0001;
        localparam logic [PORT_W-1:0] KEY_5      = 4'b1001;
        localparam logic [PORT_W-1:0] KEY_6      = 4'b0111;
        localparam logic [PORT_W-1:0] KEY_7      = 4'b1100;
        localparam logic [PORT_W-1:0] KEY_8      = 4'b1000;
        localparam logic [PORT_W-1:0] KEY_9      = 4'b1011;
        localparam logic [PORT_W-1:0] KEY_STAR   = 4'b1010;
        localparam logic [PORT_W-1:0] KEY_NUMBER = 4'b0101;
        localparam logic [PORT_W-1:0] KEY_PURPLE = 4'b0100;
        localparam logic [PORT_W-1:0] KEY_BLUE   = 4'b0010;
        localparam logic [PORT_W-1:0] KEY_NONE   = 4'b1111;

        // Lines pulled high, nothing driven
        localparam logic [PORT_W-1:0] PORT_IDLE  = 4'b1111;

        // ====================================================================
        // Direction view, active-low line positions in the nibble
        // ====================================================================
        localparam int DIR_UP    = 3;
        localparam int DIR_DOWN  = 2;
        localparam int DIR_LEFT  = 1;
        localparam int DIR_RIGHT = 0;

        // Same four port lines, read either as a key code or as directions
        typedef union packed {
                logic [PORT_W-1:0] key;
                logic [PORT_W-1:0] dir_n;
        } port_nibble_t;

endpackage

//--- ps2_keypad_emu.sv
// Keyboard keypad emulation, tracks digit, star, minus and shift keys from PS/2 events
`timescale 1ns/1ps

module ps2_keypad_emu (
        input  logic                               clk_sys,
        input  logic                               rst_n_i,
        input  logic [cv_input_pkg::PS2_KEY_W-1:0] ps2_key_i,
        output logic [cv_input_pkg::KBD_W-1:0]     kbd_btn_o
);

        logic                            toggle_q;
        logic [9:0]                      digit_q;
        logic                            star_q;
        logic                            minus_q;
        logic                            shift_q;

        logic                            new_event;
        logic                            pressed;
        logic [cv_input_pkg::SC_W-1:0]   scan;

        assign new_event = toggle_q != ps2_key_i[cv_input_pkg::PS2_TOGGLE_BIT];
        assign pressed   = ps2_key_i[cv_input_pkg::PS2_PRESSED_BIT];
        // Extended prefix bit is ignored
        assign scan      = ps2_key_i[cv_input_pkg::SC_W-1:0];

        // ====================================================================
        // Event decode
        // ====================================================================
        always_ff @(posedge clk_sys or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        toggle_q <= 1'b0;
                        digit_q  <= '0;
                        star_q   <= 1'b0;
                        minus_q  <= 1'b0;
                        shift_q  <= 1'b0;
                end else begin
                        toggle_q <= ps2_key_i[cv_input_pkg::PS2_TOGGLE_BIT];

                        if (new_event) begin
                                // Main row and numeric pad both map to the digit
                                for (int i = 0; i < 10; i++) begin
                                        if (scan == cv_input_pkg::SC_MAIN_DIGIT[i] ||
                                            scan == cv_input_pkg::SC_PAD_DIGIT[i]) begin
                                                digit_q[i] <= pressed;
                                        end
                                end

                                if (scan == cv_input_pkg::SC_STAR) begin
                                        star_q <= pressed;
                                end

                                if (scan == cv_input_pkg::SC_MINUS) begin
                                        minus_q <= pressed;
                                end

                                // Either shift key
                                if (scan == cv_input_pkg::SC_LSHIFT ||
                                    scan == cv_input_pkg::SC_RSHIFT) begin
                                        shift_q <= pressed;
                                end
                        end
                end
        end

        // ====================================================================
        // Keyboard part of the button vector
        // ====================================================================
        always_comb begin
                kbd_btn_o = '0;

                for (int i = 0; i < 10; i++) begin
                        kbd_btn_o[cv_input_pkg::KP_DIGIT0 + i] = digit_q[i];
                end

                // Shift-8 gives star, shift-3 gives number
                kbd_btn_o[cv_input_pkg::KP_STAR] =
                        star_q | (shift_q & digit_q[cv_input_pkg::KP_DIGIT8]);

                // Keypad minus also stands for number
                kbd_btn_o[cv_input_pkg::KP_NUMBER] =
                        minus_q | (shift_q & digit_q[cv_input_pkg::KP_DIGIT3]);
        end

endmodule

//--- keypad_encoder.sv
// Priority encoder from keypad buttons to the console's 4-bit key code
`timescale 1ns/1ps

module keypad_encoder (
        input  logic [cv_input_pkg::KEYPAD_ENC_W-1:0] keypad_i,
        output cv_ctrl_pkg::port_nibble_t             key_code_o
);

        logic [cv_ctrl_pkg::PORT_W-1:0] code;

        // ====================================================================
        // Lowest index wins
        // ====================================================================
        // Bit 0 is digit 0, bit 13 the blue trigger
        always_comb begin
                casez (keypad_i)
                        14'b?????????????1: code = cv_ctrl_pkg::KEY_0;
                        14'b????????????10: code = cv_ctrl_pkg::KEY_1;
                        14'b???????????100: code = cv_ctrl_pkg::KEY_2;
                        14'b??????????1000: code = cv_ctrl_pkg::KEY_3;
                        14'b?????????10000: code = cv_ctrl_pkg::KEY_4;
                        14'b????????100000: code = cv_ctrl_pkg::KEY_5;
                        14'b???????1000000: code = cv_ctrl_pkg::KEY_6;
                        14'b??????10000000: code = cv_ctrl_pkg::KEY_7;
                        14'b?????100000000: code = cv_ctrl_pkg::KEY_8;
                        14'b????1000000000: code = cv_ctrl_pkg::KEY_9;
                        // Star and number
                        14'b???10000000000: code = cv_ctrl_pkg::KEY_STAR;
                        14'b??100000000000: code = cv_ctrl_pkg::KEY_NUMBER;
                        // Side triggers
                        14'b?1000000000000: code = cv_ctrl_pkg::KEY_PURPLE;
                        14'b10000000000000: code = cv_ctrl_pkg::KEY_BLUE;
                        default:            code = cv_ctrl_pkg::KEY_NONE;
                endcase
        end

        // Console reads this nibble as a key code
        always_comb begin
                key_code_o     = '0;
                key_code_o.key = code;
        end

endmodule

//--- ctrl_player.sv
// One player's controller port, joystick mapping and keypad/joystick line multiplexing
`timescale 1ns/1ps

module ctrl_player #(
        parameter int PLAYER = 0
) (
        input  logic [cv_input_pkg::JOY_W-1:0]  joy0_i,
        input  logic [cv_input_pkg::JOY_W-1:0]  joy1_i,
        input  logic                            joy_swap_i,
        input  logic [cv_input_pkg::KBD_W-1:0]  kbd_btn_i,
        input  logic                            sel_keypad_n_i,
        input  logic                            sel_joy_n_i,
        output logic [cv_ctrl_pkg::PORT_W-1:0]  ctrl_lines_o,
        output logic                            ctrl_fire_o
);

        // Player 1 takes the second word unless swapped
        localparam bit TAKE_JOY1 = (PLAYER != 0);

        logic [cv_input_pkg::JOY_W-1:0]    joy_sel;
        logic [cv_input_pkg::KEYPAD_W-1:0] joy_btn;
        logic [cv_input_pkg::KEYPAD_W-1:0] btn;
        cv_ctrl_pkg::port_nibble_t         key_code;
        cv_ctrl_pkg::port_nibble_t         dir_view;
        logic [cv_ctrl_pkg::PORT_W-1:0]    key_lines;
        logic [cv_ctrl_pkg::PORT_W-1:0]    dir_lines;
        logic                              fire_kp_n;
        logic                              fire_joy_n;

        assign joy_sel = (joy_swap_i != TAKE_JOY1) ? joy1_i : joy0_i;

        // ====================================================================
        // Button vector
        // ====================================================================
        always_comb begin
                joy_btn = '0;

                for (int i = 0; i < 10; i++) begin
                        joy_btn[cv_input_pkg::KP_DIGIT0 + i] =
                                joy_sel[cv_input_pkg::JOY_DIGIT0 + i];
                end

                joy_btn[cv_input_pkg::KP_STAR]   = joy_sel[cv_input_pkg::JOY_STAR];
                joy_btn[cv_input_pkg::KP_NUMBER] = joy_sel[cv_input_pkg::JOY_NUMBER];
                joy_btn[cv_input_pkg::KP_PURPLE] = joy_sel[cv_input_pkg::JOY_PURPLE];
                joy_btn[cv_input_pkg::KP_BLUE]   = joy_sel[cv_input_pkg::JOY_BLUE];
                joy_btn[cv_input_pkg::KP_UP]     = joy_sel[cv_input_pkg::JOY_UP];
                joy_btn[cv_input_pkg::KP_DOWN]   = joy_sel[cv_input_pkg::JOY_DOWN];
                joy_btn[cv_input_pkg::KP_LEFT]   = joy_sel[cv_input_pkg::JOY_LEFT];
                joy_btn[cv_input_pkg::KP_RIGHT]  = joy_sel[cv_input_pkg::JOY_RIGHT];
                joy_btn[cv_input_pkg::KP_FIRE1]  = joy_sel[cv_input_pkg::JOY_FIRE1];
                joy_btn[cv_input_pkg::KP_FIRE2]  = joy_sel[cv_input_pkg::JOY_FIRE2];
        end

        // Keyboard covers the low indices only
        assign btn = joy_btn |
                     {{(cv_input_pkg::KEYPAD_W - cv_input_pkg::KBD_W){1'b0}}, kbd_btn_i};

        keypad_encoder u_keypad_encoder (
                .keypad_i   (btn[cv_input_pkg::KEYPAD_ENC_W-1:0]),
                .key_code_o (key_code)
        );

        // Direction view of the nibble, lines pulled low when pressed
        always_comb begin
                dir_view = '0;
                dir_view.dir_n[cv_ctrl_pkg::DIR_UP]    = ~btn[cv_input_pkg::KP_UP];
                dir_view.dir_n[cv_ctrl_pkg::DIR_DOWN]  = ~btn[cv_input_pkg::KP_DOWN];
                dir_view.dir_n[cv_ctrl_pkg::DIR_LEFT]  = ~btn[cv_input_pkg::KP_LEFT];
                dir_view.dir_n[cv_ctrl_pkg::DIR_RIGHT] = ~btn[cv_input_pkg::KP_RIGHT];
        end

        // ====================================================================
        // Port lines
        // ====================================================================
        // Both commons low gives a wired AND of the two views
        assign key_lines = sel_keypad_n_i ? cv_ctrl_pkg::PORT_IDLE : key_code.key;
        assign dir_lines = sel_joy_n_i ? cv_ctrl_pkg::PORT_IDLE : dir_view.dir_n;

        assign ctrl_lines_o = key_lines & dir_lines;

        // Fire 2 on the keypad common, fire 1 on the joystick common
        assign fire_kp_n  = sel_keypad_n_i | ~btn[cv_input_pkg::KP_FIRE2];
        assign fire_joy_n = sel_joy_n_i | ~btn[cv_input_pkg::KP_FIRE1];

        assign ctrl_fire_o = fire_kp_n & fire_joy_n;

endmodule

//--- cv_controller_top.sv
// Controller input path top, PS/2 keypad emulation feeding both console player ports
`timescale 1ns/1ps

module cv_controller_top (
        input  logic                               clk_sys,
        input  logic                               rst_n_i,
        input  logic [cv_input_pkg::JOY_W-1:0]     joy0_i,
        input  logic [cv_input_pkg::JOY_W-1:0]     joy1_i,
        input  logic                               joy_swap_i,
        input  logic [cv_input_pkg::PS2_KEY_W-1:0] ps2_key_i,
        input  logic [1:0]                         sel_keypad_n_i,
        input  logic [1:0]                         sel_joy_n_i,
        output logic [cv_ctrl_pkg::PORT_W-1:0]     ctrl_lines0_o,
        output logic                               ctrl_fire0_o,
        output logic [cv_ctrl_pkg::PORT_W-1:0]     ctrl_lines1_o,
        output logic                               ctrl_fire1_o
);

        // Shared by both players
        logic [cv_input_pkg::KBD_W-1:0] kbd_btn;

        ps2_keypad_emu u_ps2_keypad_emu (
                .clk_sys   (clk_sys),
                .rst_n_i   (rst_n_i),
                .ps2_key_i (ps2_key_i),
                .kbd_btn_o (kbd_btn)
        );

        // ====================================================================
        // Player ports
        // ====================================================================
        ctrl_player #(
                .PLAYER (0)
        ) u_player0 (
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .joy_swap_i     (joy_swap_i),
                .kbd_btn_i      (kbd_btn),
                .sel_keypad_n_i (sel_keypad_n_i[0]),
                .sel_joy_n_i    (sel_joy_n_i[0]),
                .ctrl_lines_o   (ctrl_lines0_o),
                .ctrl_fire_o    (ctrl_fire0_o)
        );

        ctrl_player #(
                .PLAYER (1)
        ) u_player1 (
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .joy_swap_i     (joy_swap_i),
                .kbd_btn_i      (kbd_btn),
                .sel_keypad_n_i (sel_keypad_n_i[1]),
                .sel_joy_n_i    (sel_joy_n_i[1]),
                .ctrl_lines_o   (ctrl_lines1_o),
                .ctrl_fire_o    (ctrl_fire1_o)
        );

endmodule

//--- cv_controller_properties.sv
// Bound checks on the controller port levels and the keyboard emulator output
`timescale 1ns/1ps

module cv_controller_properties (
        input logic                               clk_sys,
        input logic                               rst_n_i,
        input logic [cv_input_pkg::PS2_KEY_W-1:0] ps2_key_i,
        input logic [1:0]                         sel_keypad_n_i,
        input logic [1:0]                         sel_joy_n_i,
        input logic [cv_input_pkg::KBD_W-1:0]     kbd_btn_i,
        input logic [cv_ctrl_pkg::PORT_W-1:0]     ctrl_lines0_i,
        input logic                               ctrl_fire0_i,
        input logic [cv_ctrl_pkg::PORT_W-1:0]     ctrl_lines1_i,
        input logic                               ctrl_fire1_i
);

        // Port floats high when neither common is pulled low
        player0_idle_a: assert property (@(posedge clk_sys)
                (sel_keypad_n_i[0] && sel_joy_n_i[0]) |-> (&ctrl_lines0_i && ctrl_fire0_i))
                else $error("player 0 port not idle with both selects high");

        player1_idle_a: assert property (@(posedge clk_sys)
                (sel_keypad_n_i[1] && sel_joy_n_i[1]) |-> (&ctrl_lines1_i && ctrl_fire1_i))
                else $error("player 1 port not idle with both selects high");

        reset_idle_a: assert property (@(posedge clk_sys)
                (!rst_n_i && &sel_keypad_n_i && &sel_joy_n_i) |->
                (&ctrl_lines0_i && ctrl_fire0_i && &ctrl_lines1_i && ctrl_fire1_i))
                else $error("port outputs not idle during reset");

        // No PS/2 event, no change of the keyboard buttons
        kbd_hold_a: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
                $stable(ps2_key_i[cv_input_pkg::PS2_TOGGLE_BIT]) |=> $stable(kbd_btn_i))
                else $error("keyboard buttons changed without a PS/2 event");

endmodule

bind cv_controller_top cv_controller_properties u_properties (
        .clk_sys        (clk_sys),
        .rst_n_i        (rst_n_i),
        .ps2_key_i      (ps2_key_i),
        .sel_keypad_n_i (sel_keypad_n_i),
        .sel_joy_n_i    (sel_joy_n_i),
        .kbd_btn_i      (kbd_btn),
        .ctrl_lines0_i  (ctrl_lines0_o),
        .ctrl_fire0_i   (ctrl_fire0_o),
        .ctrl_lines1_i  (ctrl_lines1_o),
        .ctrl_fire1_i   (ctrl_fire1_o)
);

//--- tb_cv_controller.sv
// Testbench for the controller input path, replays golden vectors against the top level
`timescale 1ns/1ps

module tb_cv_controller;

        localparam string GOLDEN_FILE = "cv_controller_golden.txt";

        logic                               clk_sys;
        logic                               rst_n_i;
        logic [cv_input_pkg::JOY_W-1:0]     joy0_i;
        logic [cv_input_pkg::JOY_W-1:0]     joy1_i;
        logic                               joy_swap_i;
        logic [cv_input_pkg::PS2_KEY_W-1:0] ps2_key_i;
        logic [1:0]                         sel_keypad_n_i;
        logic [1:0]                         sel_joy_n_i;
        logic [cv_ctrl_pkg::PORT_W-1:0]     ctrl_lines0_o;
        logic                               ctrl_fire0_o;
        logic [cv_ctrl_pkg::PORT_W-1:0]     ctrl_lines1_o;
        logic                               ctrl_fire1_o;

        logic                               ps2_toggle;
        int                                 n_steps;
        bit                                 steps_known;

        cv_controller_top dut (
                .clk_sys        (clk_sys),
                .rst_n_i        (rst_n_i),
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .joy_swap_i     (joy_swap_i),
                .ps2_key_i      (ps2_key_i),
                .sel_keypad_n_i (sel_keypad_n_i),
                .sel_joy_n_i    (sel_joy_n_i),
                .ctrl_lines0_o  (ctrl_lines0_o),
                .ctrl_fire0_o   (ctrl_fire0_o),
                .ctrl_lines1_o  (ctrl_lines1_o),
                .ctrl_fire1_o   (ctrl_fire1_o)
        );

        initial begin
                clk_sys = 1'b0;
        end

        always #5 clk_sys = ~clk_sys;

        // Comment and blank lines are skipped
        function automatic bit is_data_line(input string line);
                for (int i = 0; i < line.len(); i++) begin
                        if (line[i] != " " && line[i] != "\t") begin
                                return !(line[i] == "#" || line[i] == "\n" || line[i] == "\r");
                        end
                end
                return 1'b0;
        endfunction

        task automatic count_steps(output int count);
                int    fd;
                string line;
                count = 0;
                fd = $fopen(GOLDEN_FILE, "r");
                if (fd == 0) begin
                        $display("cannot open the golden vector file %s", GOLDEN_FILE);
                        $display("ERRORS FOUND");
                        $fatal(1, "golden file missing");
                end
                while ($fgets(line, fd) > 0) begin
                        if (is_data_line(line)) begin
                                count++;
                        end
                end
                $fclose(fd);
        endtask

        // Event 1 is a make, 2 a break; each new event flips the toggle
        task automatic apply_inputs(input logic [31:0] joy0_v, input logic [31:0] joy1_v,
                                    input logic swap_v, input int event_v,
                                    input logic [7:0] scan_v, input logic [1:0] sel_kp_v,
                                    input logic [1:0] sel_joy_v);
                joy0_i         = joy0_v;
                joy1_i         = joy1_v;
                joy_swap_i     = swap_v;
                sel_keypad_n_i = sel_kp_v;
                sel_joy_n_i    = sel_joy_v;
                if (event_v != 0) begin
                        ps2_toggle = ~ps2_toggle;
                        ps2_key_i  = {ps2_toggle, (event_v == 1), 1'b0, scan_v};
                end
        endtask

        task automatic check_output(input string test_name, input string port_name,
                                    input logic [3:0] expected, input logic [3:0] actual);
                assert (actual === expected) else begin
                        $display("mismatch %s %s expected %h actual %h",
                                 test_name, port_name, expected, actual);
                        $display("ERRORS FOUND");
                        $fatal(1, "output check failed");
                end
        endtask

        // ====================================================================
        // Golden vector replay
        // ====================================================================
        initial begin
                int          fd;
                int          fields;
                int          steps_run;
                int          event_v;
                string       line;
                string       name;
                logic [31:0] joy0_v;
                logic [31:0] joy1_v;
                logic        swap_v;
                logic [7:0]  scan_v;
                logic [1:0]  sel_kp_v;
                logic [1:0]  sel_joy_v;
                logic [3:0]  lines0_exp;
                logic [3:0]  lines1_exp;
                logic        fire0_exp;
                logic        fire1_exp;

                rst_n_i        = 1'b0;
                joy0_i         = '0;
                joy1_i         = '0;
                joy_swap_i     = 1'b0;
                ps2_key_i      = '0;
                ps2_toggle     = 1'b0;
                sel_keypad_n_i = 2'b11;
                sel_joy_n_i    = 2'b11;
                steps_run      = 0;

                count_steps(n_steps);
                steps_known = 1'b1;

                repeat (2) @(posedge clk_sys);
                #1;
                rst_n_i = 1'b1;

                fd = $fopen(GOLDEN_FILE, "r");
                while ($fgets(line, fd) > 0) begin
                        if (is_data_line(line)) begin
                                fields = $sscanf(line, "%s %h %h %b %d %h %b %b %h %b %h %b",
                                                 name, joy0_v, joy1_v, swap_v, event_v, scan_v,
                                                 sel_kp_v, sel_joy_v, lines0_exp, fire0_exp,
                                                 lines1_exp, fire1_exp);
                                if (fields != 12) begin
                                        $display("malformed golden line: %s", line);
                                        $display("ERRORS FOUND");
                                        $fatal(1, "bad golden vector");
                                end
                                apply_inputs(joy0_v, joy1_v, swap_v, event_v, scan_v,
                                             sel_kp_v, sel_joy_v);
                                // Keyboard buttons settle on the next edge
                                @(posedge clk_sys);
                                #1;
                                check_output(name, "lines0", lines0_exp, ctrl_lines0_o);
                                check_output(name, "fire0", {3'b000, fire0_exp},
                                             {3'b000, ctrl_fire0_o});
                                check_output(name, "lines1", lines1_exp, ctrl_lines1_o);
                                check_output(name, "fire1", {3'b000, fire1_exp},
                                             {3'b000, ctrl_fire1_o});
                                steps_run++;
                        end
                end
                $fclose(fd);

                if (steps_run == n_steps && steps_run > 0) begin
                        $display("NO ERRORS");
                        $finish;
                end else begin
                        $display("ran %0d of %0d golden steps", steps_run, n_steps);
                        $display("ERRORS FOUND");
                        $fatal(1, "golden replay incomplete");
                end
        end

        // Four cycles per golden step plus reset margin
        initial begin
                wait (steps_known);
                repeat (n_steps * 4 + 20) @(posedge clk_sys);
                $display("watchdog expired, the run did not finish in time");
                $display("ERRORS FOUND");
                $fatal(1, "simulation stopped by watchdog");
        end

endmodule

//--- cv_controller_golden.txt
# name joy0 joy1 swap event(0 none,1 make,2 break) scan sel_kp_n sel_joy_n lines0 fire0 lines1 fire1
# joy words, scan code and lines in hex; selects in binary as {player1,player0}
idle_sel_hi 00000000 00000000 0 0 00 11 11 f 1 f 1
idle_kp 00000000 00000000 0 0 00 00 11 f 1 f 1
idle_both 00000000 00000000 0 0 00 00 00 f 1 f 1
joy_digit5_7 0000a000 00000000 0 0 00 00 11 9 1 f 1
joy_digit2_9_fire2 00020420 00000000 0 0 00 00 11 d 0 f 1
joy_star_number 00080040 00040080 0 0 00 00 11 a 1 5 1
dir_up_right 00000019 00000006 0 0 00 11 00 6 0 9 1
dir_fire_split 00000020 00000010 0 0 00 11 00 f 1 f 0
both_sel_p0 00000232 00000000 0 0 00 00 00 c 0 f 1
both_sel_p1 00000000 00000104 0 0 00 00 00 f 1 3 1
mixed_sel 00001008 00004021 0 0 00 10 01 1 1 e 1
swap_kp 00001008 00004021 1 0 00 00 11 7 0 1 1
swap_joy 00001008 00004021 1 0 00 11 00 e 1 7 1
kbd_main4_make 00000000 00000000 0 1 25 00 11 1 1 1 1
kbd_pad2_make 00000000 00000000 0 1 72 00 11 d 1 d 1
kbd_pad2_break 00000000 00000000 0 2 72 00 11 1 1 1 1
kbd_main4_break 00000000 00000000 0 2 25 00 11 f 1 f 1
kbd_pad0_make 00000000 00000000 0 1 70 00 11 3 1 3 1
kbd_main0_break 00000000 00000000 0 2 45 00 11 f 1 f 1
kbd_lshift_make 00000000 00000000 0 1 12 00 11 f 1 f 1
kbd_main8_shift 00000000 00000000 0 1 3e 00 11 8 1 8 1
kbd_main8_break 00000000 00000000 0 2 3e 00 11 f 1 f 1
kbd_pad3_shift 00000000 00000000 0 1 7a 00 11 6 1 6 1
kbd_pad3_break 00000000 00000000 0 2 7a 00 11 f 1 f 1
kbd_lshift_break 00000000 00000000 0 2 12 00 11 f 1 f 1
kbd_minus_make 00000000 00000000 0 1 7b 00 11 5 1 5 1
kbd_minus_joy 00080000 00020000 0 0 00 00 11 5 1 b 1
kbd_minus_break 00000000 00000000 0 2 7b 00 11 f 1 f 1
kbd_star_make 00000000 00000000 0 1 7c 00 11 a 1 a 1
kbd_star_break 00000000 00000000 0 2 7c 00 11 f 1 f 1
kbd_rshift_make 00000000 00000000 0 1 59 00 11 f 1 f 1
kbd_main3_shift 00000000 00000000 0 1 26 00 11 6 1 6 1
idle_end 00000000 00000000 0 0 00 11 11 f 1 f 1

//--- verilog.f
cv_input_pkg.sv
cv_ctrl_pkg.sv
ps2_keypad_emu.sv
keypad_encoder.sv
ctrl_player.sv
cv_controller_top.sv
cv_controller_properties.sv
tb_cv_controller.sv
